//--- design/isa_pkg.sv
// ISA widths and encodings shared by the execute stage; RV32-style scalar side, 16 matrix regs
package isa_pkg;

    localparam int WORD_W     = 32; // scalar datapath width
    localparam int REG_IDX_W  = 5;  // 32 scalar registers
    localparam int MREG_IDX_W = 4;  // 16 matrix registers

    typedef logic [WORD_W-1:0]     word_t;     // data word
    typedef logic [WORD_W-1:0]     addr_t;     // byte address
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;  // scalar register index
    typedef logic [MREG_IDX_W-1:0] mreg_idx_t; // matrix register index

    // sequential instruction step, byte addressed
    localparam addr_t PC_STEP = 32'd4;

    // scalar ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,  // shift amount from low 5 bits
        SRL,
        SRA,
        SLT,  // signed compare
        SLTU  // unsigned compare
    } alu_op_e;

    // branch and jump kinds handled by the branch unit
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,  // pc relative
        JALR  // register relative, bit 0 dropped
    } branch_type_e;

    // scalar memory access, word sized only
    typedef enum logic {
        LW,
        SW
    } mem_type_e;

endpackage

//--- design/exec_pkg.sv
// request and response bundles of the execute stage; completion bit order is fixed
package exec_pkg;
    import isa_pkg::*;

    // scalar ALU
    typedef struct packed {
        alu_op_e  aluop;
        word_t    port_a;
        word_t    port_b;
        reg_idx_t rd;       // passed on to writeback
    } salu_req_t;

    typedef struct packed {
        word_t result;
        logic  negative;
        logic  overflow;    // add/sub only
        logic  zero;
    } salu_resp_t;

    // branch unit
    typedef struct packed {
        branch_type_e branch_type;
        word_t        reg_a;
        word_t        reg_b;
        addr_t        current_pc;
        word_t        imm;
        logic         predicted_outcome; // 1 = predicted taken
        reg_idx_t     rd;                // link register for jumps
    } bfu_req_t;

    typedef struct packed {
        logic  branch_outcome; // taken
        logic  miss;           // outcome differs from prediction
        addr_t correct_pc;
        logic  update_btb;
        logic  update_pc;      // redirect fetch, one cycle
        addr_t branch_target;
        word_t jump_wdat;      // link value pc + 4
        logic  br_jump;
    } bfu_resp_t;

    // scalar load/store and the data cache side
    typedef struct packed {
        mem_type_e mem_type;
        word_t     rs1;     // base
        word_t     rs2;     // store data
        word_t     imm;
        reg_idx_t  rd;
    } sls_req_t;

    typedef struct packed {
        addr_t addr;
        logic  ren;
        logic  wen;
        word_t store_data;
    } dmem_req_t;

    // matrix load/store and GEMM issue
    typedef struct packed {
        logic      ls;      // 0 load, 1 store
        mreg_idx_t rd;
        word_t     base;
        word_t     imm;
    } mls_req_t;

    typedef struct packed {
        mreg_idx_t rs1;
        mreg_idx_t rs2;
        mreg_idx_t rs3;
        mreg_idx_t rd;
        logic      new_weight; // reload array weights
    } gemm_req_t;

    typedef enum logic [1:0] {
        SP_LOAD,
        SP_STORE,
        SP_GEMM
    } sp_kind_e;

    typedef struct packed {
        sp_kind_e  kind;
        mreg_idx_t rd;
        mreg_idx_t rs1;
        mreg_idx_t rs2;
        mreg_idx_t rs3;
        logic      new_weight;
        addr_t     addr;       // matrix base, loads and stores only
    } sp_req_t;

    // completion vector to the scoreboard
    typedef logic [4:0] fu_ex_t;

    localparam int FU_ALU  = 0;
    localparam int FU_SLS  = 1;
    localparam int FU_BFU  = 2;
    localparam int FU_MLS  = 3;
    localparam int FU_GEMM = 4;

endpackage

//--- design/fu_alu.sv
// purely combinational ALU; shifts use port_b[4:0], overflow flag meaningful for ADD and SUB only
`timescale 1ns/1ps

module fu_alu import isa_pkg::*, exec_pkg::*; (
    input  salu_req_t  req,
    output salu_resp_t resp
);

    word_t result;
    logic  overflow;

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (req.aluop)
            ADD: begin
                result   = req.port_a + req.port_b;
                // same sign in, other sign out
                overflow = (req.port_a[31] == req.port_b[31]) &&
                           (result[31] != req.port_a[31]);
            end
            SUB: begin
                result   = req.port_a - req.port_b;
                overflow = (req.port_a[31] != req.port_b[31]) &&
                           (result[31] != req.port_a[31]);
            end
            AND:  result = req.port_a & req.port_b;
            OR:   result = req.port_a | req.port_b;
            XOR:  result = req.port_a ^ req.port_b;
            SLL:  result = req.port_a << req.port_b[4:0];
            SRL:  result = req.port_a >> req.port_b[4:0];
            SRA:  result = word_t'($signed(req.port_a) >>> req.port_b[4:0]); // sign fill
            SLT:  result = {31'd0, $signed(req.port_a) < $signed(req.port_b)};
            SLTU: result = {31'd0, req.port_a < req.port_b};
            default: result = '0;
        endcase
    end

    // flags straight off the result
    always_comb begin
        resp.result   = result;
        resp.negative = result[31];
        resp.overflow = overflow;
        resp.zero     = (result == '0);
    end

endmodule

//--- design/fu_branch.sv
// branch resolution, outputs one cycle after enable; payload holds its value until the next enable
`timescale 1ns/1ps

module fu_branch import isa_pkg::*, exec_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      enable,
    input  bfu_req_t  req,
    output bfu_resp_t resp,
    output logic      resolved
);

    logic      taken;
    logic      is_jump;
    addr_t     target;
    addr_t     fall_through;
    bfu_resp_t resp_next;
    bfu_resp_t resp_q;      // registered payload
    logic      update_pc_q; // redirect pulse

    // condition evaluation
    always_comb begin
        is_jump = (req.branch_type == JAL) || (req.branch_type == JALR);
        case (req.branch_type)
            BEQ:       taken = (req.reg_a == req.reg_b);
            BNE:       taken = (req.reg_a != req.reg_b);
            BLT:       taken = ($signed(req.reg_a) < $signed(req.reg_b));
            BGE:       taken = ($signed(req.reg_a) >= $signed(req.reg_b));
            BLTU:      taken = (req.reg_a < req.reg_b);
            BGEU:      taken = (req.reg_a >= req.reg_b);
            JAL, JALR: taken = 1'b1; // jumps always go
            default:   taken = 1'b0;
        endcase
    end

    // target and fall-through
    always_comb begin
        fall_through = req.current_pc + PC_STEP;
        if (req.branch_type == JALR) begin
            target    = req.reg_a + req.imm;
            target[0] = 1'b0; // jalr drops bit 0
        end else begin
            target = req.current_pc + req.imm;
        end
    end

    always_comb begin
        resp_next.branch_outcome = taken;
        resp_next.miss           = (taken != req.predicted_outcome);
        resp_next.correct_pc     = taken ? target : fall_through;
        resp_next.update_btb     = taken && !is_jump;           // conditional taken only
        resp_next.update_pc      = resp_next.miss || is_jump;
        resp_next.branch_target  = target;
        resp_next.jump_wdat      = fall_through;                // link value
        resp_next.br_jump        = is_jump;
    end

    always_ff @(posedge CLK) begin
        if (enable) begin
            resp_q <= resp_next;
        end
    end

    // single-cycle strobes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resolved    <= 1'b0;
            update_pc_q <= 1'b0;
        end else begin
            resolved    <= enable;
            update_pc_q <= enable && resp_next.update_pc;
        end
    end

    always_comb begin
        resp           = resp_q;
        resp.update_pc = update_pc_q; // pulse, not held
    end

endmodule

//--- design/fu_scalar_ls.sv
// one outstanding word access at a time; enable is ignored unless idle, cache latency unbounded
`timescale 1ns/1ps

module fu_scalar_ls import isa_pkg::*, exec_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      enable,
    input  sls_req_t  req,
    input  logic      dhit_in,
    input  word_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output logic      dhit,
    output word_t     load_data,
    output reg_idx_t  rd
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS, // request held toward the cache
        DONE    // hit reported to writeback
    } sls_state_e;

    sls_state_e state, next_state;

    // captured request
    addr_t     addr_q;
    word_t     store_q;
    mem_type_e type_q;
    reg_idx_t  rd_q;
    word_t     load_q;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (enable) next_state = ACCESS;
            ACCESS:  if (dhit_in) next_state = DONE;   // wait as long as the cache needs
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && enable) begin
            addr_q  <= req.rs1 + req.imm; // effective address
            store_q <= req.rs2;
            type_q  <= req.mem_type;
            rd_q    <= req.rd;
        end
        if (state == ACCESS && dhit_in) begin
            load_q <= dmem_rdata;         // store hits capture don't-care data
        end
    end

    // cache side
    always_comb begin
        dmem_req.addr       = addr_q;
        dmem_req.store_data = store_q;
        dmem_req.ren        = (state == ACCESS) && (type_q == LW);
        dmem_req.wen        = (state == ACCESS) && (type_q == SW);
    end

    assign dhit      = (state == DONE); // one cycle pulse
    assign load_data = load_q;
    assign rd        = rd_q;

endmodule

//--- design/sp_request_gen.sv
// mls_enable and gemm_enable are held levels, never both high; one sp_write per rising enable
`timescale 1ns/1ps

module sp_request_gen import exec_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      mls_enable,
    input  mls_req_t  mls_req,
    input  logic      gemm_enable,
    input  gemm_req_t gemm_req,
    output sp_req_t   sp_req,
    output logic      sp_write
);

    sp_req_t mls_sp;
    sp_req_t gemm_sp;
    logic    mls_edge;  // enable seen last cycle
    logic    gemm_edge;

    always_comb begin
        mls_sp            = '0;
        mls_sp.kind       = mls_req.ls ? SP_STORE : SP_LOAD;
        mls_sp.rd         = mls_req.rd;
        mls_sp.addr       = mls_req.base + mls_req.imm;
        gemm_sp           = '0;
        gemm_sp.kind      = SP_GEMM;
        gemm_sp.rs1       = gemm_req.rs1;
        gemm_sp.rs2       = gemm_req.rs2;
        gemm_sp.rs3       = gemm_req.rs3;
        gemm_sp.rd        = gemm_req.rd;
        gemm_sp.new_weight = gemm_req.new_weight;
    end

    assign sp_req   = mls_enable ? mls_sp : gemm_sp; // matrix ls wins, gemm otherwise
    assign sp_write = (mls_enable && !mls_edge) || (gemm_enable && !gemm_edge);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mls_edge  <= 1'b0;
            gemm_edge <= 1'b0;
        end else begin
            mls_edge  <= mls_enable;
            gemm_edge <= gemm_enable;
        end
    end

endmodule

//--- design/execute.sv
// execute stage top; scratchpad enables are held levels, the rest one-cycle strobes, no back-pressure
`timescale 1ns/1ps

module execute import isa_pkg::*, exec_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    // scalar ALU
    input  logic       salu_enable,
    input  salu_req_t  salu_req,
    output salu_resp_t salu_resp,
    output reg_idx_t   salu_rd,
    // branch unit
    input  logic       bfu_enable,
    input  bfu_req_t   bfu_req,
    output bfu_resp_t  bfu_resp,
    output logic       bfu_resolved,
    output reg_idx_t   jump_rd,
    // scalar load/store and data cache
    input  logic       sls_enable,
    input  sls_req_t   sls_req,
    input  logic       dhit_in,
    input  word_t      dmem_rdata,
    output dmem_req_t  dmem_req,
    output word_t      sls_load_data,
    output logic       sls_dhit,
    output reg_idx_t   sls_rd,
    // scratchpad side
    input  logic       mls_enable,
    input  mls_req_t   mls_req,
    input  logic       gemm_enable,
    input  gemm_req_t  gemm_req,
    input  logic       load_complete,
    input  logic       store_complete,
    input  logic       gemm_complete,
    output sp_req_t    sp_req,
    output logic       sp_write,
    // completions to the scoreboard
    output fu_ex_t     fu_ex
);

    fu_alu i_fu_alu (
        .req  (salu_req),
        .resp (salu_resp)
    );

    assign salu_rd = salu_req.rd; // same cycle as the result

    fu_branch i_fu_branch (
        .CLK      (CLK),
        .nRST     (nRST),
        .enable   (bfu_enable),
        .req      (bfu_req),
        .resp     (bfu_resp),
        .resolved (bfu_resolved)
    );

    // link register straight from the request, scoreboard keeps it for the resolve cycle
    assign jump_rd = bfu_req.rd;

    fu_scalar_ls i_fu_scalar_ls (
        .CLK        (CLK),
        .nRST       (nRST),
        .enable     (sls_enable),
        .req        (sls_req),
        .dhit_in    (dhit_in),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .dhit       (sls_dhit),
        .load_data  (sls_load_data),
        .rd         (sls_rd)
    );

    sp_request_gen i_sp_request_gen (
        .CLK         (CLK),
        .nRST        (nRST),
        .mls_enable  (mls_enable),
        .mls_req     (mls_req),
        .gemm_enable (gemm_enable),
        .gemm_req    (gemm_req),
        .sp_req      (sp_req),
        .sp_write    (sp_write)
    );

    // completion vector
    always_comb begin
        fu_ex          = '0;
        fu_ex[FU_ALU]  = salu_enable;                      // combinational unit
        fu_ex[FU_SLS]  = sls_dhit;
        fu_ex[FU_BFU]  = bfu_resolved;
        fu_ex[FU_MLS]  = load_complete || store_complete;  // reported by scratchpad
        fu_ex[FU_GEMM] = gemm_complete;
    end

endmodule

//--- sim/execute_asserts.sv
// bound into execute; every check is off while nRST is low, sls issue while busy is a scoreboard error
`timescale 1ns/1ps

module execute_asserts import exec_pkg::*; (
    input logic      CLK,
    input logic      nRST,
    input logic      bfu_enable,
    input logic      bfu_resolved,
    input logic      sls_enable,
    input dmem_req_t dmem_req,
    input logic      sp_write
);

    // one write per scratchpad issue
    sp_write_one_cycle: assert property (
        @(posedge CLK) disable iff (!nRST) sp_write |=> !sp_write
    ) else $error("sp_write high for two cycles in a row");

    // no new scalar access while the cache request is still out
    sls_issue_while_busy: assert property (
        @(posedge CLK) disable iff (!nRST) (dmem_req.ren || dmem_req.wen) |-> !sls_enable
    ) else $error("sls_enable while the dmem request is active");

    // resolve exactly one cycle after the enable and never without it
    bfu_resolve_follows: assert property (
        @(posedge CLK) disable iff (!nRST) bfu_enable |=> bfu_resolved
    ) else $error("bfu_resolved missing one cycle after bfu_enable");

    bfu_resolve_has_cause: assert property (
        @(posedge CLK) disable iff (!nRST) bfu_resolved |-> $past(bfu_enable)
    ) else $error("bfu_resolved without bfu_enable in the cycle before");

    dmem_read_write_exclusive: assert property (
        @(posedge CLK) disable iff (!nRST) !(dmem_req.ren && dmem_req.wen)
    ) else $error("dmem read and write enables high together");

endmodule

//--- sim/execute_tb.sv
// stimulus from sim/execute_stim.txt, run from the project root; cache model is 16 words, addr[5:2]
`timescale 1ns/1ps

module execute_tb
    import isa_pkg::*, exec_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 16;
    localparam int    TIMEOUT      = 20;        // cycles per wait
    localparam int    WATCHDOG_NS  = 1_000_000;
    localparam int    SEED         = 40040;
    localparam string STIM_FILE    = "sim/execute_stim.txt";

    logic       CLK;
    logic       nRST;
    logic       salu_enable;
    salu_req_t  salu_req;
    salu_resp_t salu_resp;
    reg_idx_t   salu_rd;
    logic       bfu_enable;
    bfu_req_t   bfu_req;
    bfu_resp_t  bfu_resp;
    logic       bfu_resolved;
    reg_idx_t   jump_rd;
    logic       sls_enable;
    sls_req_t   sls_req;
    logic       dhit_in    = 1'b0;  // driven by the cache model
    word_t      dmem_rdata = '0;
    dmem_req_t  dmem_req;
    word_t      sls_load_data;
    logic       sls_dhit;
    reg_idx_t   sls_rd;
    logic       mls_enable;
    mls_req_t   mls_req;
    logic       gemm_enable;
    gemm_req_t  gemm_req;
    logic       load_complete;
    logic       store_complete;
    logic       gemm_complete;
    sp_req_t    sp_req;
    logic       sp_write;
    fu_ex_t     fu_ex;

    word_t  fld [0:9];       // fields of the current stimulus line
    int     line_no      = 0;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    word_t  cache_mem [0:15];
    logic   cache_busy   = 1'b0;
    int     cache_wait   = 0;
    integer seed         = SEED;

    execute i_execute (.*);

    bind execute execute_asserts i_execute_asserts (
        .CLK          (CLK),
        .nRST         (nRST),
        .bfu_enable   (bfu_enable),
        .bfu_resolved (bfu_resolved),
        .sls_enable   (sls_enable),
        .dmem_req     (dmem_req),
        .sp_write     (sp_write)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // data cache with a random hit latency of 1 to 4 cycles
    always @(posedge CLK) begin : cache_model
        int k;
        dhit_in <= 1'b0;
        if (!nRST) begin
            cache_busy <= 1'b0;
            for (k = 0; k < 16; k++) begin
                cache_mem[k] = 32'hc0de0000 | (k << 2); // byte address as fill
            end
        end else if (cache_busy) begin
            if (cache_wait == 0) begin
                dhit_in    <= 1'b1;
                dmem_rdata <= cache_mem[dmem_req.addr[5:2]]; // old word before any store
                if (dmem_req.wen) begin
                    cache_mem[dmem_req.addr[5:2]] = dmem_req.store_data;
                end
                cache_busy <= 1'b0;
            end else begin
                cache_wait <= cache_wait - 1;
            end
        end else if ((dmem_req.ren || dmem_req.wen) && !dhit_in) begin
            cache_busy <= 1'b1;
            cache_wait <= $random(seed) & 3;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past its limit of %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not respond within %0d cycles", what, TIMEOUT);
        errors++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d problem(s)", name, errors - errs_before);
        end
    endtask

    task automatic drive_alu(input string name);
        int errs;
        errs = errors;
        @(posedge CLK);
        salu_enable     <= 1'b1;
        salu_req.aluop  <= alu_op_e'(fld[0][3:0]);
        salu_req.port_a <= fld[1];
        salu_req.port_b <= fld[2];
        salu_req.rd     <= reg_idx_t'(line_no);
        @(negedge CLK);                            // combinational result in the same cycle
        check_value({name, " result"}, fld[3], salu_resp.result);
        check_value({name, " negative"}, 32'(fld[4][8]), 32'(salu_resp.negative));
        check_value({name, " overflow"}, 32'(fld[4][4]), 32'(salu_resp.overflow));
        check_value({name, " zero"}, 32'(fld[4][0]), 32'(salu_resp.zero));
        check_value({name, " rd"}, 32'(reg_idx_t'(line_no)), 32'(salu_rd));
        check_value({name, " fu_ex[0]"}, 32'd1, 32'(fu_ex[FU_ALU]));
        @(posedge CLK);
        salu_enable <= 1'b0;
        close_test(name, errs);
    endtask

    task automatic resolve_branch(input string name);
        int errs;
        int n;
        errs = errors;
        @(posedge CLK);
        bfu_enable                <= 1'b1;
        bfu_req.branch_type       <= branch_type_e'(fld[0][2:0]);
        bfu_req.reg_a             <= fld[1];
        bfu_req.reg_b             <= fld[2];
        bfu_req.current_pc        <= fld[3];
        bfu_req.imm               <= fld[4];
        bfu_req.predicted_outcome <= fld[5][0];
        bfu_req.rd                <= fld[6][4:0];
        n = 0;
        @(negedge CLK);
        while (!bfu_resolved && n < TIMEOUT) begin
            @(posedge CLK);
            bfu_enable <= 1'b0;                    // strobe only
            @(negedge CLK);
            n++;
        end
        if (!bfu_resolved) begin
            report_timeout("branch unit");
        end else begin
            check_value({name, " latency"}, 32'd1, 32'(n));
            check_value({name, " target"}, fld[7], bfu_resp.branch_target);
            check_value({name, " correct_pc"}, fld[8], bfu_resp.correct_pc);
            check_value({name, " outcome"}, 32'(fld[9][16]), 32'(bfu_resp.branch_outcome));
            check_value({name, " miss"}, 32'(fld[9][12]), 32'(bfu_resp.miss));
            check_value({name, " update_btb"}, 32'(fld[9][8]), 32'(bfu_resp.update_btb));
            check_value({name, " update_pc"}, 32'(fld[9][4]), 32'(bfu_resp.update_pc));
            check_value({name, " br_jump"}, 32'(fld[9][0]), 32'(bfu_resp.br_jump));
            check_value({name, " fu_ex[2]"}, 32'd1, 32'(fu_ex[FU_BFU]));
            if (fld[9][0]) begin
                check_value({name, " link data"}, fld[3] + 32'd4, bfu_resp.jump_wdat);
                check_value({name, " jump_rd"}, 32'(fld[6][4:0]), 32'(jump_rd));
            end
            @(negedge CLK);                        // both strobes gone again
            check_value({name, " resolved width"}, 32'd0, 32'(bfu_resolved));
            check_value({name, " update_pc width"}, 32'd0, 32'(bfu_resp.update_pc));
        end
        close_test(name, errs);
    endtask

    task automatic access_memory(input string name);
        int errs;
        int n;
        errs = errors;
        @(posedge CLK);
        sls_enable       <= 1'b1;
        sls_req.mem_type <= mem_type_e'(fld[0][0]);
        sls_req.rs1      <= fld[1];
        sls_req.rs2      <= fld[2];
        sls_req.imm      <= fld[3];
        sls_req.rd       <= fld[4][4:0];
        @(posedge CLK);
        sls_enable <= 1'b0;
        n = 0;
        @(negedge CLK);
        while (!(dmem_req.ren || dmem_req.wen) && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (!(dmem_req.ren || dmem_req.wen)) begin
            report_timeout("scalar load/store request");
        end else begin
            check_value({name, " addr"}, fld[1] + fld[3], dmem_req.addr);
            check_value({name, " wen"}, 32'(fld[0][0]), 32'(dmem_req.wen));
            if (fld[0][0]) begin
                check_value({name, " store data"}, fld[2], dmem_req.store_data);
            end
            n = 0;
            while (!sls_dhit && n < TIMEOUT) begin // cache delay varies
                @(negedge CLK);
                n++;
            end
            if (!sls_dhit) begin
                report_timeout("data cache hit");
            end else begin
                check_value({name, " rd"}, 32'(fld[4][4:0]), 32'(sls_rd));
                check_value({name, " fu_ex[1]"}, 32'd1, 32'(fu_ex[FU_SLS]));
                if (!fld[0][0]) begin
                    check_value({name, " load data"}, fld[5], sls_load_data);
                end
                @(negedge CLK);
                check_value({name, " hit width"}, 32'd0, 32'(sls_dhit));
            end
        end
        close_test(name, errs);
    endtask

    task automatic issue_matrix_ls(input string name);
        int      errs;
        int      i;
        int      writes;
        sp_req_t got;
        errs   = errors;
        writes = 0;
        got    = '0;
        @(posedge CLK);
        mls_enable   <= 1'b1;                      // level for the whole op
        mls_req.ls   <= fld[0][0];
        mls_req.rd   <= fld[1][3:0];
        mls_req.base <= fld[2];
        mls_req.imm  <= fld[3];
        for (i = 0; i < fld[4]; i++) begin
            @(negedge CLK);
            if (sp_write) begin
                writes++;
                got = sp_req;
            end
            @(posedge CLK);
        end
        mls_enable <= 1'b0;
        check_value({name, " writes"}, 32'd1, 32'(writes));
        check_value({name, " kind"}, 32'(fld[0][0] ? SP_STORE : SP_LOAD), 32'(got.kind));
        check_value({name, " addr"}, fld[5], got.addr);
        check_value({name, " rd"}, 32'(fld[1][3:0]), 32'(got.rd));
        close_test(name, errs);
    endtask

    task automatic issue_gemm(input string name);
        int      errs;
        int      i;
        int      writes;
        sp_req_t got;
        errs   = errors;
        writes = 0;
        got    = '0;
        @(posedge CLK);
        gemm_enable         <= 1'b1;
        gemm_req.rs1        <= fld[0][3:0];
        gemm_req.rs2        <= fld[1][3:0];
        gemm_req.rs3        <= fld[2][3:0];
        gemm_req.rd         <= fld[3][3:0];
        gemm_req.new_weight <= fld[4][0];
        for (i = 0; i < fld[5]; i++) begin
            @(negedge CLK);
            if (sp_write) begin
                writes++;
                got = sp_req;
            end
            @(posedge CLK);
        end
        gemm_enable <= 1'b0;
        check_value({name, " writes"}, 32'd1, 32'(writes));
        check_value({name, " kind"}, 32'(SP_GEMM), 32'(got.kind));
        check_value({name, " rs1"}, 32'(fld[0][3:0]), 32'(got.rs1));
        check_value({name, " rs2"}, 32'(fld[1][3:0]), 32'(got.rs2));
        check_value({name, " rs3"}, 32'(fld[2][3:0]), 32'(got.rs3));
        check_value({name, " rd"}, 32'(fld[3][3:0]), 32'(got.rd));
        check_value({name, " new_weight"}, 32'(fld[4][0]), 32'(got.new_weight));
        close_test(name, errs);
    endtask

    task automatic pulse_completions(input string name);
        int errs;
        errs = errors;
        @(posedge CLK);
        load_complete  <= fld[0][0];
        store_complete <= fld[1][0];
        gemm_complete  <= fld[2][0];
        @(negedge CLK);
        check_value({name, " fu_ex[4]"}, 32'(fld[3][4]), 32'(fu_ex[FU_GEMM]));
        check_value({name, " fu_ex[3]"}, 32'(fld[3][0]), 32'(fu_ex[FU_MLS]));
        @(posedge CLK);
        load_complete  <= 1'b0;
        store_complete <= 1'b0;
        gemm_complete  <= 1'b0;
        close_test(name, errs);
    endtask

    initial begin : main
        int          fd;
        int          k;
        int          errs;
        logic [7:0]  kind;
        string       line;
        string       tname;
        nRST           = 1'b0;
        salu_enable    = 1'b0;
        salu_req       = '0;
        bfu_enable     = 1'b0;
        bfu_req        = '0;
        sls_enable     = 1'b0;
        sls_req        = '0;
        mls_enable     = 1'b0;
        mls_req        = '0;
        gemm_enable    = 1'b0;
        gemm_req       = '0;
        load_complete  = 1'b0;
        store_complete = 1'b0;
        gemm_complete  = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // idle outputs out of reset
        errs = errors;
        @(negedge CLK);
        check_value("reset sp_write", 32'd0, 32'(sp_write));
        check_value("reset ren", 32'd0, 32'(dmem_req.ren));
        check_value("reset wen", 32'd0, 32'(dmem_req.wen));
        check_value("reset sls_dhit", 32'd0, 32'(sls_dhit));
        check_value("reset bfu_resolved", 32'd0, 32'(bfu_resolved));
        check_value("reset update_pc", 32'd0, 32'(bfu_resp.update_pc));
        close_test("reset", errs);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                if (line.len() < 2 || line[0] == "#") begin
                    continue;                      // blank or column notes
                end
                for (k = 0; k < 10; k++) begin
                    fld[k] = '0;
                end
                kind = 8'h00;
                void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", kind,
                              fld[0], fld[1], fld[2], fld[3], fld[4],
                              fld[5], fld[6], fld[7], fld[8], fld[9]));
                tname = $sformatf("line %0d", line_no);
                case (kind)
                    "A":     drive_alu({"alu ", tname});
                    "B":     resolve_branch({"branch ", tname});
                    "S":     access_memory({"scalar ls ", tname});
                    "M":     issue_matrix_ls({"matrix ls ", tname});
                    "G":     issue_gemm({"gemm ", tname});
                    "C":     pulse_completions({"completion ", tname});
                    default: begin
                        $display("unknown operation on line %0d of the stimulus file", line_no);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d problems in all",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
design/isa_pkg.sv
design/exec_pkg.sv
design/fu_alu.sv
design/fu_branch.sv
design/fu_scalar_ls.sv
design/sp_request_gen.sv
design/execute.sv
sim/execute_asserts.sv
sim/execute_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the execute stage testbench with Verilator, run from any directory
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module execute_tb -o execute_sim

./obj_dir/execute_sim > sim.log 2>&1 || true
cat sim.log

if grep -Fxq '** PASS **' sim.log; then
    exit 0
fi
echo "simulation did not report a pass, see sim.log"
exit 1

//--- sim/execute_stim.txt
# A op a b result nvz | B type a b pc imm pred rd target correct_pc ombuj (one hex digit per flag)
# S type rs1 rs2 imm rd data | M ls rd base imm hold addr | G s1 s2 s3 rd nw hold | C ld st gm ex43
A 0 00000005 00000007 0000000c 000
A 0 7fffffff 00000001 80000000 110
A 1 00000003 00000003 00000000 001
A 1 80000000 00000001 7fffffff 010
A 2 f0f0f0f0 ff00ff00 f000f000 100
A 3 0000f000 000000ff 0000f0ff 000
A 4 aaaaaaaa aaaaaaaa 00000000 001
A 5 00000001 0000001f 80000000 100
A 6 80000000 00000004 08000000 000
A 7 80000000 00000004 f8000000 100
A 8 ffffffff 00000001 00000001 000
A 9 ffffffff 00000001 00000000 001
B 0 00000010 00000010 00001000 00000040 1 00 00001040 00001040 10100
B 1 00000005 00000005 00002000 00000020 1 00 00002020 00002004 01010
B 2 ffffffff 00000001 00003000 fffffff0 0 00 00002ff0 00002ff0 11110
B 3 ffffffff 00000001 00003100 00000010 0 00 00003110 00003104 00000
B 4 ffffffff 00000001 00004000 00000008 1 00 00004008 00004004 01010
B 6 00000000 00000000 00005000 00000200 1 01 00005200 00005200 10011
B 7 00006003 00000000 00005200 00000010 1 1f 00006012 00006012 10011
B 7 00007001 00000000 00005300 00000000 0 05 00007000 00007000 11011
S 1 00000100 cafef00d 00000008 00 00000000
S 0 00000100 00000000 00000008 0a cafef00d
S 1 00000200 12345678 fffffffc 00 00000000
S 0 000001f0 00000000 0000000c 1b 12345678
M 0 3 00010000 00000040 4 00010040
M 1 7 00020000 00000100 3 00020100
G 1 2 3 4 1 4
G a b c d 0 3
C 1 0 0 01
C 0 1 0 01
C 0 0 1 10
C 1 0 1 11
